// ==== filelist.f ====
hdl/accel_pkg.sv
hdl/sync_fifo.sv
hdl/line_ram.sv
hdl/burst_packer.sv
hdl/cmd_sequencer.sv
hdl/gemm_engine.sv
hdl/accel_top.sv
bench/accel_properties.sv
bench/accel_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing --assert -j 0
TOP       = accel_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/accel_tb.sv ====
`timescale 1ns/100ps

module accel_tb;

	localparam int ACT_LINES   = 8;
	localparam int CYCLE_LIMIT = 20000;  // roughly ten times the whole run

	logic                 okClk;
	logic                 i_rst;
	logic                 i_cmd_wr;
	accel_pkg::cmd_word_t i_cmd_data;
	logic                 o_cmd_full;
	logic                 i_load_clr;
	logic                 i_d_wr;
	accel_pkg::sample_t   i_d_data;
	logic                 i_w_wr;
	accel_pkg::sample_t   i_w_data;
	logic                 i_res_rd;
	accel_pkg::result_t   o_res_data;
	logic                 o_res_valid;
	logic                 o_irq;

	// host side copies of both line rams
	accel_pkg::line_t   act_mem [256];
	accel_pkg::line_t   wgt_mem [256];
	accel_pkg::result_t exp_q [$];
	int   seed;
	int   irq_count = 0;
	int   irq_exp   = 0;
	int   cycles    = 0;
	logic drain_en;

	accel_top i_dut (
		.okClk       (okClk),
		.i_rst       (i_rst),
		.i_cmd_wr    (i_cmd_wr),
		.i_cmd_data  (i_cmd_data),
		.o_cmd_full  (o_cmd_full),
		.i_load_clr  (i_load_clr),
		.i_d_wr      (i_d_wr),
		.i_d_data    (i_d_data),
		.i_w_wr      (i_w_wr),
		.i_w_data    (i_w_data),
		.i_res_rd    (i_res_rd),
		.o_res_data  (o_res_data),
		.o_res_valid (o_res_valid),
		.o_irq       (o_irq)
	);

	initial begin
		okClk = 1'b0;
		forever #10 okClk = ~okClk;
	end

	task automatic fail_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping at first error");
	endtask

	always @(posedge okClk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the DUT stopped making progress", cycles);
			fail_run();
		end
	end

	// expected value of output o, straight from the layer rule
	function automatic accel_pkg::result_t ref_result(input logic [2:0] op, input int ic,
			input int o, input int wb, input accel_pkg::sample_t bias);
		accel_pkg::result_t acc;
		int wline;
		acc = bias;
		for (int k = 0; k < ic; k++) begin
			wline = (wb + o * ic + k) % 256;
			for (int j = 0; j < accel_pkg::BURST_LEN; j++) begin
				acc = acc + int'(act_mem[k][j]) * int'(wgt_mem[wline][j]);
			end
		end
		if (op == accel_pkg::OP_GEMM_RELU && acc < 0) begin
			acc = 0;
		end
		return acc;
	endfunction

	task automatic compare_result(input accel_pkg::result_t got);
		accel_pkg::result_t exp;
		if (exp_q.size() == 0) begin
			$display("result %0d came out at %0t with no result pending", got, $time);
			fail_run();
		end else begin
			exp = exp_q.pop_front();
			if (got !== exp) begin
				$display("MISMATCH at %0t: result %0d, expected %0d", $time, got, exp);
				fail_run();
			end
		end
	endtask

	task automatic compare_irq(input int expected);
		if (irq_count != expected) begin
			$display("MISMATCH at %0t: %0d interrupts, expected %0d", $time, irq_count,
				expected);
			fail_run();
		end
	endtask

	// host reads every result it sees unless draining is paused
	initial begin
		forever begin
			@(negedge okClk);
			if (drain_en && o_res_valid && !i_rst) begin
				compare_result(o_res_data);
				i_res_rd = 1'b1;
			end else begin
				i_res_rd = 1'b0;
			end
		end
	end

	initial begin
		forever begin
			@(negedge okClk);
			if (o_irq) begin
				irq_count = irq_count + 1;
			end
		end
	end

	// clears both packers, then fills ACT_LINES activation and n_wgt weight lines
	task automatic load_lines(input int mode, input int n_wgt);
		accel_pkg::sample_t d;
		accel_pkg::sample_t w;
		int line;
		int lane;
		@(negedge okClk);
		i_load_clr = 1'b1;
		for (int i = 0; i < n_wgt * accel_pkg::BURST_LEN; i++) begin
			line = i / accel_pkg::BURST_LEN;
			lane = i % accel_pkg::BURST_LEN;
			if (mode == 0) begin
				d = 16'($random(seed));
				w = 16'($random(seed));
			end else begin
				// small positive activations, weights negative on lines 2 and 3 of every 4
				d = 16'($random(seed) & 32'hff);
				w = 16'($random(seed) & 32'hff);
				if (line % 4 >= 2) begin
					w = -w;
				end
			end
			@(negedge okClk);
			i_load_clr = 1'b0;
			i_d_wr     = (line < ACT_LINES);
			i_d_data   = d;
			i_w_wr     = 1'b1;
			i_w_data   = w;
			if (line < ACT_LINES) begin
				act_mem[line][lane] = d;
			end
			wgt_mem[line][lane] = w;
		end
		@(negedge okClk);
		i_d_wr = 1'b0;
		i_w_wr = 1'b0;
	endtask

	task automatic send_cmd(input logic [2:0] op, input logic [7:0] ic, input logic [7:0] oc,
			input logic [7:0] wb, input accel_pkg::sample_t bias);
		accel_pkg::cmd_hdr_t hdr;
		hdr           = '0;
		hdr.op_type   = op;
		hdr.i_channel = ic;
		hdr.o_channel = oc;
		hdr.w_base    = wb;
		@(negedge okClk);
		if (o_cmd_full) begin
			$display("command FIFO full at %0t, command cannot be queued", $time);
			fail_run();
		end else begin
			i_cmd_wr   = 1'b1;
			i_cmd_data = hdr;
			@(negedge okClk);
			i_cmd_data = {16'h0000, bias};
			@(negedge okClk);
			i_cmd_wr = 1'b0;
			irq_exp  = irq_exp + 1;  // rejected commands interrupt too
			if ((op == accel_pkg::OP_GEMM || op == accel_pkg::OP_GEMM_RELU) &&
					ic != 0 && oc != 0) begin
				for (int o = 0; o < oc; o++) begin
					exp_q.push_back(ref_result(op, ic, o, wb, bias));
				end
			end
		end
	endtask

	task automatic wait_idle();
		while (irq_count < irq_exp || o_res_valid) begin
			@(negedge okClk);
		end
		repeat (4) @(negedge okClk);  // room for a stray interrupt
		compare_irq(irq_exp);
		if (exp_q.size() != 0) begin
			$display("%0d expected results never came out", exp_q.size());
			fail_run();
		end
	endtask

	initial begin
		seed       = 32'h75b9253f;
		drain_en   = 1'b1;
		i_rst      = 1'b1;
		i_cmd_wr   = 1'b0;
		i_cmd_data = '0;
		i_load_clr = 1'b0;
		i_d_wr     = 1'b0;
		i_d_data   = '0;
		i_w_wr     = 1'b0;
		i_w_data   = '0;
		i_res_rd   = 1'b0;
		repeat (16) @(negedge okClk);
		i_rst = 1'b0;
		if (o_res_valid || o_cmd_full || o_irq) begin
			$display("outputs not idle after reset");
			fail_run();
		end

		// full weight ram so the wrap case has data at the top
		load_lines(0, 256);

		send_cmd(accel_pkg::OP_GEMM, 8'd3, 8'd4, 8'd0, 16'($random(seed)));
		wait_idle();

		// 40 outputs into a 32 deep result FIFO while the host is not reading
		drain_en = 1'b0;
		send_cmd(accel_pkg::OP_GEMM, 8'd1, 8'd40, 8'd10, -16'sd77);
		while (!i_dut.res_full) begin
			@(negedge okClk);
		end
		repeat (20) @(negedge okClk);
		compare_irq(irq_exp - 1);  // engine still held
		drain_en = 1'b1;
		wait_idle();

		send_cmd(3'd5, 8'd2, 8'd2, 8'd0, 16'sd0);  // unsupported op
		send_cmd(accel_pkg::OP_GEMM, 8'd2, 8'd0, 8'd0, 16'sd0);
		send_cmd(accel_pkg::OP_GEMM, 8'd2, 8'd3, 8'd20, 16'sd300);
		wait_idle();

		// back to back, second one runs over line 255 into 0 and 1
		send_cmd(accel_pkg::OP_GEMM, 8'd3, 8'd2, 8'd100, 16'($random(seed)));
		send_cmd(accel_pkg::OP_GEMM_RELU, 8'd2, 8'd4, 8'd250, 16'($random(seed)));
		send_cmd(accel_pkg::OP_GEMM, 8'd8, 8'd1, 8'd60, 16'($random(seed)));
		wait_idle();

		// odd outputs go negative and get clamped
		load_lines(1, 16);
		send_cmd(accel_pkg::OP_GEMM_RELU, 8'd2, 8'd6, 8'd0, 16'sd100);
		wait_idle();

		load_lines(0, 16);
		send_cmd(accel_pkg::OP_GEMM, 8'd4, 8'd3, 8'd2, 16'($random(seed)));
		wait_idle();

		if (exp_q.size() == 0 && irq_count == irq_exp) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("results or interrupts left over at the end of the run");
			fail_run();
		end
	end

endmodule

// ==== bench/accel_properties.sv ====
`timescale 1ns/100ps

module accel_properties (
	input logic               okClk,
	input logic               i_rst,
	input logic               i_start,
	input logic               i_ready,
	input logic               i_done,
	input logic               i_res_vld,
	input accel_pkg::result_t i_res,
	input logic               i_res_full
);

	// sequencer only starts an idle engine
	start_when_ready: assert property (@(posedge okClk) disable iff (i_rst)
		i_start |-> i_ready)
		else $error("start pulsed while the engine was busy");

	// a blocked result waits in place until the FIFO has room
	result_held_when_full: assert property (@(posedge okClk) disable iff (i_rst)
		(i_res_vld && i_res_full) |=> (i_res_vld && $stable(i_res)))
		else $error("pending result lost or changed while the FIFO was full");

	done_single_cycle: assert property (@(posedge okClk) disable iff (i_rst)
		i_done |=> !i_done)
		else $error("done held longer than one cycle");

	ready_after_reset: assert property (@(posedge okClk)
		i_rst |=> i_ready)
		else $error("engine not ready after reset");

endmodule

bind gemm_engine accel_properties u_props (
	.okClk      (okClk),
	.i_rst      (i_rst),
	.i_start    (i_start),
	.i_ready    (o_ready),
	.i_done     (o_done),
	.i_res_vld  (res_vld),
	.i_res      (o_res),
	.i_res_full (i_res_full)
);

// ==== hdl/accel_top.sv ====
`timescale 1ns/100ps

module accel_top (
	input  logic                 okClk,
	input  logic                 i_rst,
	input  logic                 i_cmd_wr,
	input  accel_pkg::cmd_word_t i_cmd_data,
	output logic                 o_cmd_full,
	input  logic                 i_load_clr,
	input  logic                 i_d_wr,
	input  accel_pkg::sample_t   i_d_data,
	input  logic                 i_w_wr,
	input  accel_pkg::sample_t   i_w_data,
	input  logic                 i_res_rd,
	output accel_pkg::result_t   o_res_data,
	output logic                 o_res_valid,
	output logic                 o_irq
);

	// command path
	logic                 cmd_valid;
	logic                 cmd_rd;
	accel_pkg::cmd_word_t cmd_word;
	// sequencer to engine
	logic                   eng_ready;
	logic                   eng_start;
	logic                   eng_done;
	accel_pkg::layer_desc_t desc;
	// line rams
	logic [accel_pkg::RAM_AW-1:0] d_raddr;
	logic [accel_pkg::RAM_AW-1:0] w_raddr;
	accel_pkg::line_t             d_line;
	accel_pkg::line_t             w_line;
	// result path
	logic               res_wr;
	logic               res_full;
	accel_pkg::result_t res;

	sync_fifo #(
		.payload_t (accel_pkg::cmd_word_t),
		.DEPTH     (accel_pkg::CMD_FIFO_DEPTH)
	) u_cmd_fifo (
		.okClk   (okClk),
		.i_rst   (i_rst),
		.i_wr    (i_cmd_wr),
		.i_data  (i_cmd_data),
		.o_full  (o_cmd_full),
		.i_rd    (cmd_rd),
		.o_data  (cmd_word),
		.o_valid (cmd_valid)
	);

	burst_packer u_d_packer (
		.okClk    (okClk),
		.i_rst    (i_rst),
		.i_clr    (i_load_clr),
		.i_wr     (i_d_wr),
		.i_sample (i_d_data),
		.i_raddr  (d_raddr),
		.o_rdata  (d_line)
	);

	burst_packer u_w_packer (
		.okClk    (okClk),
		.i_rst    (i_rst),
		.i_clr    (i_load_clr),
		.i_wr     (i_w_wr),
		.i_sample (i_w_data),
		.i_raddr  (w_raddr),
		.o_rdata  (w_line)
	);

	cmd_sequencer u_seq (
		.okClk       (okClk),
		.i_rst       (i_rst),
		.i_cmd_valid (cmd_valid),
		.i_cmd       (cmd_word),
		.o_cmd_rd    (cmd_rd),
		.i_eng_ready (eng_ready),
		.o_start     (eng_start),
		.o_desc      (desc),
		.i_eng_done  (eng_done),
		.o_irq       (o_irq)
	);

	gemm_engine u_engine (
		.okClk      (okClk),
		.i_rst      (i_rst),
		.i_start    (eng_start),
		.i_desc     (desc),
		.o_ready    (eng_ready),
		.o_done     (eng_done),
		.o_d_raddr  (d_raddr),
		.i_d_line   (d_line),
		.o_w_raddr  (w_raddr),
		.i_w_line   (w_line),
		.o_res_wr   (res_wr),
		.o_res      (res),
		.i_res_full (res_full)
	);

	sync_fifo #(
		.payload_t (accel_pkg::result_t),
		.DEPTH     (accel_pkg::RES_FIFO_DEPTH)
	) u_res_fifo (
		.okClk   (okClk),
		.i_rst   (i_rst),
		.i_wr    (res_wr),
		.i_data  (res),
		.o_full  (res_full),
		.i_rd    (i_res_rd),
		.o_data  (o_res_data),
		.o_valid (o_res_valid)
	);

endmodule

// ==== hdl/gemm_engine.sv ====
`timescale 1ns/100ps

module gemm_engine (
	input  logic                         okClk,
	input  logic                         i_rst,
	input  logic                         i_start,
	input  accel_pkg::layer_desc_t       i_desc,
	output logic                         o_ready,
	output logic                         o_done,
	output logic [accel_pkg::RAM_AW-1:0] o_d_raddr,
	input  accel_pkg::line_t             i_d_line,
	output logic [accel_pkg::RAM_AW-1:0] o_w_raddr,
	input  accel_pkg::line_t             i_w_line,
	output logic                         o_res_wr,
	output accel_pkg::result_t           o_res,
	input  logic                         i_res_full
);

	accel_pkg::layer_desc_t desc_q;
	logic issuing;
	logic step;  // whole pipeline moves
	logic [7:0] k_cnt;
	logic [7:0] o_cnt;
	logic [accel_pkg::RAM_AW-1:0] w_ptr;
	logic last_k;
	logic last_o;
	// address stage
	logic a_vld, a_first, a_last, a_final;
	logic [accel_pkg::RAM_AW-1:0] a_d_addr, a_w_addr;
	// ram stage
	logic r_vld, r_first, r_last, r_final;
	logic [accel_pkg::RAM_AW-1:0] r_d_addr, r_w_addr;
	// mac stage
	accel_pkg::result_t acc, dot, sum;
	logic res_vld, res_final;

	assign step   = !i_res_full;
	assign last_k = (k_cnt == desc_q.i_channel - 1'b1);
	assign last_o = (o_cnt == desc_q.o_channel - 1'b1);

	// when frozen, re-read the lines held in the ram stage so its data stays put
	assign o_d_raddr = step ? a_d_addr : r_d_addr;
	assign o_w_raddr = step ? a_w_addr : r_w_addr;

	assign o_res_wr = res_vld && step;

	always_comb begin
		dot = '0;
		for (int j = 0; j < accel_pkg::BURST_LEN; j++) begin
			dot = dot + i_d_line[j] * i_w_line[j];
		end
		// first line of an output starts from the bias
		sum = (r_first ? accel_pkg::result_t'(desc_q.bias) : acc) + dot;
	end

	always_ff @(posedge okClk) begin
		if (i_rst) begin
			o_ready <= 1'b1;
			o_done  <= 1'b0;
			issuing <= 1'b0;
			a_vld   <= 1'b0;
			r_vld   <= 1'b0;
			res_vld <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (o_ready && i_start) begin
				o_ready <= 1'b0;
				issuing <= 1'b1;
			end
			if (step) begin
				a_vld   <= issuing;
				r_vld   <= a_vld;
				res_vld <= r_vld && r_last;
				if (issuing && last_k && last_o) begin
					issuing <= 1'b0;  // final line issued
				end
				if (res_vld && res_final) begin
					o_done  <= 1'b1;  // last result leaves this cycle
					o_ready <= 1'b1;
				end
			end
		end
	end

	// counters and pipeline payload
	always_ff @(posedge okClk) begin
		if (o_ready && i_start) begin
			desc_q <= i_desc;
			k_cnt  <= '0;
			o_cnt  <= '0;
			w_ptr  <= i_desc.w_base;
		end else if (step && issuing) begin
			w_ptr <= w_ptr + 1'b1;  // weight lines are contiguous, wraps at 256
			if (last_k) begin
				k_cnt <= '0;
				o_cnt <= o_cnt + 1'b1;
			end else begin
				k_cnt <= k_cnt + 1'b1;
			end
		end
		if (step) begin
			a_d_addr <= k_cnt;
			a_w_addr <= w_ptr;
			a_first  <= (k_cnt == 0);
			a_last   <= last_k;
			a_final  <= last_k && last_o;
			r_d_addr <= a_d_addr;
			r_w_addr <= a_w_addr;
			r_first  <= a_first;
			r_last   <= a_last;
			r_final  <= a_final;
			res_final <= r_final;
			if (r_vld) begin
				acc <= sum;
			end
			// relu only for OP_GEMM_RELU
			if (desc_q.op_type == accel_pkg::OP_GEMM_RELU && sum < 0) begin
				o_res <= '0;
			end else begin
				o_res <= sum;
			end
		end
	end

endmodule

// ==== hdl/cmd_sequencer.sv ====
`timescale 1ns/100ps

module cmd_sequencer (
	input  logic                   okClk,
	input  logic                   i_rst,
	input  logic                   i_cmd_valid,
	input  accel_pkg::cmd_word_t   i_cmd,
	output logic                   o_cmd_rd,
	input  logic                   i_eng_ready,
	output logic                   o_start,
	output accel_pkg::layer_desc_t o_desc,
	input  logic                   i_eng_done,
	output logic                   o_irq
);

	typedef enum logic [2:0] {S_IDLE, S_HDR, S_BIAS, S_START, S_WAIT} state_t;

	state_t state;
	accel_pkg::cmd_hdr_t hdr_q;
	logic op_ok;
	logic cmd_ok;

	assign op_ok = (hdr_q.op_type == accel_pkg::OP_GEMM) ||
		(hdr_q.op_type == accel_pkg::OP_GEMM_RELU);
	assign cmd_ok = op_ok && (hdr_q.i_channel != 0) && (hdr_q.o_channel != 0);

	// pop word 0 in S_HDR, word 1 as soon as it shows up
	assign o_cmd_rd = (state == S_HDR) || (state == S_BIAS && i_cmd_valid);

	always_ff @(posedge okClk) begin
		if (state == S_HDR) begin
			hdr_q <= accel_pkg::cmd_hdr_t'(i_cmd);
		end
		if (state == S_BIAS && i_cmd_valid) begin
			o_desc.op_type   <= hdr_q.op_type;
			o_desc.i_channel <= hdr_q.i_channel;
			o_desc.o_channel <= hdr_q.o_channel;
			o_desc.w_base    <= hdr_q.w_base;
			o_desc.bias      <= i_cmd[15:0];  // low half of word 1
		end
	end

	always_ff @(posedge okClk) begin
		if (i_rst) begin
			state   <= S_IDLE;
			o_start <= 1'b0;
			o_irq   <= 1'b0;
		end else begin
			o_start <= 1'b0;
			o_irq   <= 1'b0;
			case (state)
				S_IDLE: begin
					if (i_cmd_valid) begin
						state <= S_HDR;
					end
				end
				S_HDR: state <= S_BIAS;
				S_BIAS: begin
					if (i_cmd_valid) begin
						if (cmd_ok) begin
							state <= S_START;
						end else begin
							// bad op or empty layer, drop it but still interrupt
							state <= S_IDLE;
							o_irq <= 1'b1;
						end
					end
				end
				S_START: begin
					if (i_eng_ready) begin
						o_start <= 1'b1;
						state   <= S_WAIT;
					end
				end
				S_WAIT: begin
					if (i_eng_done) begin
						o_irq <= 1'b1;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// ==== hdl/burst_packer.sv ====
`timescale 1ns/100ps

module burst_packer (
	input  logic                         okClk,
	input  logic                         i_rst,
	input  logic                         i_clr,
	input  logic                         i_wr,
	input  accel_pkg::sample_t           i_sample,
	input  logic [accel_pkg::RAM_AW-1:0] i_raddr,
	output accel_pkg::line_t             o_rdata
);

	accel_pkg::line_t line_q;
	accel_pkg::line_t line_next;
	logic [$clog2(accel_pkg::BURST_LEN)-1:0] lane_cnt;
	logic [accel_pkg::RAM_AW-1:0] waddr;
	logic line_we;

	// new sample comes in at the top, older ones slide toward lane 0
	assign line_next = {i_sample, line_q[accel_pkg::BURST_LEN-1:1]};
	assign line_we   = i_wr && (lane_cnt == accel_pkg::BURST_LEN-1);  // last lane of the line

	always_ff @(posedge okClk) begin
		if (i_wr) begin
			line_q <= line_next;
		end
	end

	always_ff @(posedge okClk) begin
		if (i_rst || i_clr) begin
			lane_cnt <= '0;
			waddr    <= '0;
		end else if (i_wr) begin
			if (line_we) begin
				lane_cnt <= '0;
				waddr    <= waddr + 1'b1;
			end else begin
				lane_cnt <= lane_cnt + 1'b1;
			end
		end
	end

	line_ram u_ram (
		.okClk   (okClk),
		.i_we    (line_we),
		.i_waddr (waddr),
		.i_wdata (line_next),  // full line incl. the sample being written
		.i_raddr (i_raddr),
		.o_rdata (o_rdata)
	);

endmodule

// ==== hdl/line_ram.sv ====
`timescale 1ns/100ps

module line_ram (
	input  logic                         okClk,
	input  logic                         i_we,
	input  logic [accel_pkg::RAM_AW-1:0] i_waddr,
	input  accel_pkg::line_t             i_wdata,
	input  logic [accel_pkg::RAM_AW-1:0] i_raddr,
	output accel_pkg::line_t             o_rdata
);

	// one wide word per line
	logic [accel_pkg::LINE_W-1:0] mem [2**accel_pkg::RAM_AW];

	always_ff @(posedge okClk) begin
		if (i_we) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// registered read, old contents on a same-address write
	always_ff @(posedge okClk) begin
		o_rdata <= accel_pkg::line_t'(mem[i_raddr]);
	end

endmodule

// ==== hdl/sync_fifo.sv ====
`timescale 1ns/100ps

module sync_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int  DEPTH     = 16
) (
	input  logic     okClk,
	input  logic     i_rst,
	input  logic     i_wr,
	input  payload_t i_data,
	output logic     o_full,
	input  logic     i_rd,
	output payload_t o_data,
	output logic     o_valid
);

	payload_t mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]   wr_ptr;
	logic [$clog2(DEPTH)-1:0]   rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;
	logic push;
	logic pop;

	assign o_full  = (count == DEPTH);
	assign o_valid = (count != 0);
	assign o_data  = mem[rd_ptr];  // head shows without a read
	assign push    = i_wr && !o_full;   // writes while full are dropped
	assign pop     = i_rd && o_valid;

	always_ff @(posedge okClk) begin
		if (push) begin
			mem[wr_ptr] <= i_data;
		end
	end

	always_ff @(posedge okClk) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == DEPTH-1) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == DEPTH-1) ? '0 : rd_ptr + 1'b1;
			end
			// occupancy only moves when one side acts alone
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== hdl/accel_pkg.sv ====
package accel_pkg;

	// line geometry
	localparam int BURST_LEN = 4;
	localparam int LINE_W    = 16 * BURST_LEN;
	localparam int RAM_AW    = 8;  // 256 lines per ram

	localparam int CMD_FIFO_DEPTH = 16;
	localparam int RES_FIFO_DEPTH = 32;

	// op codes, anything else gets rejected by the sequencer
	localparam logic [2:0] OP_GEMM      = 3'd1;
	localparam logic [2:0] OP_GEMM_RELU = 3'd2;

	typedef logic signed [15:0] sample_t;
	typedef sample_t [BURST_LEN-1:0] line_t;  // lane 0 holds the first sample
	typedef logic [31:0] cmd_word_t;
	typedef logic signed [31:0] result_t;

	// command word 0, op code sits in the low bits
	typedef struct packed {
		logic [7:0] w_base;     // first weight line
		logic [7:0] o_channel;  // number of outputs
		logic [7:0] i_channel;  // lines per dot product
		logic [4:0] spare;
		logic [2:0] op_type;
	} cmd_hdr_t;

	// what the engine needs for one layer
	typedef struct packed {
		logic [2:0]         op_type;
		logic [7:0]         i_channel;
		logic [7:0]         o_channel;
		logic [7:0]         w_base;
		logic signed [15:0] bias;
	} layer_desc_t;

endpackage
